// File: hw/simmem_bank_consts.svh
/*
 * Sizing constants for the message bank
 * Identifier count and width, slot pool capacity, slot address and payload widths
 */

`ifndef SIMMEM_BANK_CONSTS_SVH
`define SIMMEM_BANK_CONSTS_SVH

// Number of AXI identifiers with their own list
`define SIMMEM_NUM_IDS 4
`define SIMMEM_ID_W 2

// Shared slot pool
`define SIMMEM_CAPACITY 8
`define SIMMEM_SLOT_W 3

// Response payload without the identifier
`define SIMMEM_PAYLOAD_W 16

`endif

// File: hw/simmem_msg_pkg.sv
/*
 * Message field types
 * AXI identifier and response payload words
 */

`include "simmem_bank_consts.svh"

package simmem_msg_pkg;

  // AXI identifier of a stored response
  typedef logic [`SIMMEM_ID_W-1:0] msg_id_t;

  // Response payload, stored in the payload RAM
  typedef logic [`SIMMEM_PAYLOAD_W-1:0] msg_payload_t;

endpackage

// File: hw/simmem_list_pkg.sv
/*
 * Slot and list bookkeeping types
 * Slot index, one-bit-per-slot map and list length
 */

`include "simmem_bank_consts.svh"

package simmem_list_pkg;

  // Index of a slot in the shared pool
  typedef logic [`SIMMEM_SLOT_W-1:0] slot_addr_t;

  // One bit per slot, set while the slot is in use
  typedef logic [`SIMMEM_CAPACITY-1:0] slot_map_t;

  // List length, 0 up to the full capacity
  typedef logic [`SIMMEM_SLOT_W:0] list_len_t;

endpackage

// File: hw/simmem_slot_alloc.sv
/*
 * Producer side of the message bank
 * Used-slot map, lowest-free-slot search, push and payload write,
 * credit return for freed slots
 */

`include "simmem_bank_consts.svh"

module simmem_slot_alloc
  import simmem_msg_pkg::*, simmem_list_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Credit ingress
  input  logic         i_in_valid,
  input  msg_id_t      i_in_id,
  input  msg_payload_t i_in_payload,

  // Slot returned by the consumer
  input  logic         i_free_valid,
  input  slot_addr_t   i_free_slot,

  // Push towards the consumer
  output logic         o_push_valid,
  output msg_id_t      o_push_id,
  output slot_addr_t   o_push_slot,

  // Payload write towards the buffer
  output logic         o_pay_we,
  output slot_addr_t   o_pay_addr,
  output msg_payload_t o_pay_data,

  output logic         o_credit
);

  ////////////////////////////////////////////////////////////////////////////
  // Free slot search
  ////////////////////////////////////////////////////////////////////////////

  slot_map_t  used_q;
  slot_map_t  used_d;
  slot_addr_t nxt_free_slot;
  logic       credit_q;

  // Priority search, lowest free index wins
  // Walking down lets the lowest hit overwrite the others
  always_comb begin
    nxt_free_slot = '0;
    for (int i = `SIMMEM_CAPACITY - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        nxt_free_slot = slot_addr_t'(i);
      end
    end
  end

  // The sender only sends with a credit, so a free slot always exists here
  always_comb begin
    used_d = used_q;
    if (i_free_valid) begin
      used_d[i_free_slot] = 1'b0;
    end
    if (i_in_valid) begin
      used_d[nxt_free_slot] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Push and payload write, same cycle as the input
  ////////////////////////////////////////////////////////////////////////////

  assign o_push_valid = i_in_valid;
  assign o_push_id    = i_in_id;
  assign o_push_slot  = nxt_free_slot;

  assign o_pay_we   = i_in_valid;
  assign o_pay_addr = nxt_free_slot;
  assign o_pay_data = i_in_payload;

  // One credit pulse per freed slot, one cycle after the free
  assign o_credit = credit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q   <= '0;
      credit_q <= 1'b0;
    end else begin
      used_q   <= used_d;
      credit_q <= i_free_valid;
    end
  end

endmodule

// File: hw/simmem_list_store.sv
/*
 * Storage of the message bank
 * Payload RAM with registered read, next-slot pointer RAM with direct read
 */

`include "simmem_bank_consts.svh"

module simmem_list_store
  import simmem_msg_pkg::*, simmem_list_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Payload port, written by the producer and read by the consumer
  input  logic         i_pay_we,
  input  slot_addr_t   i_pay_addr,
  input  msg_payload_t i_pay_data,
  input  logic         i_pay_re,
  input  slot_addr_t   i_pay_raddr,
  output msg_payload_t o_pay_rdata,

  // Next-slot pointers of the per-identifier lists
  input  logic         i_link_we,
  input  slot_addr_t   i_link_addr,
  input  slot_addr_t   i_link_data,
  input  slot_addr_t   i_link_raddr,
  output slot_addr_t   o_link_rdata
);

  msg_payload_t pay_mem  [`SIMMEM_CAPACITY];
  slot_addr_t   link_mem [`SIMMEM_CAPACITY];
  msg_payload_t pay_rdata_q;

  always_ff @(posedge clk_i) begin
    if (i_pay_we) begin
      pay_mem[i_pay_addr] <= i_pay_data;
    end
    if (i_link_we) begin
      link_mem[i_link_addr] <= i_link_data;
    end
  end

  // Read data register feeds the output payload directly
  // It holds between reads, which keeps the egress stable under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pay_rdata_q <= '0;
    end else if (i_pay_re) begin
      pay_rdata_q <= pay_mem[i_pay_raddr];
    end
  end

  assign o_pay_rdata = pay_rdata_q;

  // Pointer read is combinational so the head can advance in the release cycle
  assign o_link_rdata = link_mem[i_link_raddr];

endmodule

// File: hw/simmem_release_arb.sv
/*
 * Consumer side of the message bank
 * Per-identifier head, tail and length, link writes on push,
 * fixed-priority release, output register and slot free
 */

`include "simmem_bank_consts.svh"

module simmem_release_arb
  import simmem_msg_pkg::*, simmem_list_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Push from the producer
  input  logic       i_push_valid,
  input  msg_id_t    i_push_id,
  input  slot_addr_t i_push_slot,

  // Link RAM access
  output logic       o_link_we,
  output slot_addr_t o_link_addr,
  output slot_addr_t o_link_data,
  output slot_addr_t o_link_raddr,
  input  slot_addr_t i_link_rdata,

  // Payload read, data shows up one cycle later
  output logic       o_pay_re,
  output slot_addr_t o_pay_raddr,

  // Slot handed back to the producer
  output logic       o_free_valid,
  output slot_addr_t o_free_slot,

  // Egress handshake
  input  logic       i_out_ready,
  output logic       o_out_valid,
  output msg_id_t    o_out_id
);

  slot_addr_t head_q [`SIMMEM_NUM_IDS];
  slot_addr_t head_d [`SIMMEM_NUM_IDS];
  slot_addr_t tail_q [`SIMMEM_NUM_IDS];
  slot_addr_t tail_d [`SIMMEM_NUM_IDS];
  list_len_t  len_q  [`SIMMEM_NUM_IDS];
  list_len_t  len_d  [`SIMMEM_NUM_IDS];

  logic       out_valid_q;
  msg_id_t    out_id_q;
  slot_addr_t out_slot_q;
  logic       free_valid_q;
  slot_addr_t free_slot_q;

  logic       out_xfer;
  logic       any_pending;
  logic       release_en;
  msg_id_t    rel_id;

  ////////////////////////////////////////////////////////////////////////////
  // Release choice
  ////////////////////////////////////////////////////////////////////////////

  assign out_xfer = out_valid_q && i_out_ready;

  // Lowest non-empty identifier, found by a downward walk
  always_comb begin
    rel_id      = '0;
    any_pending = 1'b0;
    for (int i = `SIMMEM_NUM_IDS - 1; i >= 0; i--) begin
      if (len_q[i] != '0) begin
        rel_id      = msg_id_t'(i);
        any_pending = 1'b1;
      end
    end
  end

  // Output register empty or leaving this cycle
  assign release_en = any_pending && (!out_valid_q || i_out_ready);

  // Head payload and its successor are read in the release cycle
  assign o_pay_re     = release_en;
  assign o_pay_raddr  = head_q[rel_id];
  assign o_link_raddr = head_q[rel_id];

  // Append behind the old tail when the list is not empty
  assign o_link_we   = i_push_valid && (len_q[i_push_id] != '0);
  assign o_link_addr = tail_q[i_push_id];
  assign o_link_data = i_push_slot;

  ////////////////////////////////////////////////////////////////////////////
  // List pointers
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `SIMMEM_NUM_IDS; i++) begin
      head_d[i] = head_q[i];
      tail_d[i] = tail_q[i];
      len_d[i]  = len_q[i];

      if (i_push_valid && i_push_id == msg_id_t'(i)) begin
        tail_d[i] = i_push_slot;
        len_d[i]  = len_d[i] + list_len_t'(1);
        // First element of an empty list
        if (len_q[i] == '0) begin
          head_d[i] = i_push_slot;
        end
      end

      if (release_en && rel_id == msg_id_t'(i)) begin
        len_d[i] = len_d[i] - list_len_t'(1);
        // Last element gone: a push in the same cycle becomes the head,
        // its link write is not visible yet
        if (len_q[i] == list_len_t'(1)) begin
          if (i_push_valid && i_push_id == msg_id_t'(i)) begin
            head_d[i] = i_push_slot;
          end
        end else begin
          head_d[i] = i_link_rdata;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '{default: '0};
      tail_q <= '{default: '0};
      len_q  <= '{default: '0};
    end else begin
      head_q <= head_d;
      tail_q <= tail_d;
      len_q  <= len_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register and slot free
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q  <= 1'b0;
      free_valid_q <= 1'b0;
    end else begin
      if (release_en) begin
        out_valid_q <= 1'b1;
      end else if (i_out_ready) begin
        out_valid_q <= 1'b0;
      end
      // Slot goes back one cycle after the transfer
      free_valid_q <= out_xfer;
    end
  end

  always_ff @(posedge clk_i) begin
    if (release_en) begin
      out_id_q   <= rel_id;
      out_slot_q <= head_q[rel_id];
    end
    if (out_xfer) begin
      free_slot_q <= out_slot_q;
    end
  end

  assign o_out_valid  = out_valid_q;
  assign o_out_id     = out_id_q;
  assign o_free_valid = free_valid_q;
  assign o_free_slot  = free_slot_q;

endmodule

// File: hw/simmem_bank.sv
/*
 * Top level of the linked-list message bank
 * Slot allocator, list storage and release arbiter
 */

`include "simmem_bank_consts.svh"

module simmem_bank
  import simmem_msg_pkg::*, simmem_list_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Credit ingress
  input  logic         i_in_valid,
  input  msg_id_t      i_in_id,
  input  msg_payload_t i_in_payload,
  output logic         o_credit,

  // Valid/ready egress
  output logic         o_out_valid,
  output msg_id_t      o_out_id,
  output msg_payload_t o_out_payload,
  input  logic         i_out_ready
);

  // Producer to consumer
  logic         push_valid;
  msg_id_t      push_id;
  slot_addr_t   push_slot;

  // Payload RAM ports
  logic         pay_we;
  slot_addr_t   pay_addr;
  msg_payload_t pay_data;
  logic         pay_re;
  slot_addr_t   pay_raddr;

  // Link RAM ports
  logic         link_we;
  slot_addr_t   link_addr;
  slot_addr_t   link_data;
  slot_addr_t   link_raddr;
  slot_addr_t   link_rdata;

  // Consumer to producer
  logic         free_valid;
  slot_addr_t   free_slot;

  simmem_slot_alloc u_slot_alloc (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_in_valid   (i_in_valid),
    .i_in_id      (i_in_id),
    .i_in_payload (i_in_payload),
    .i_free_valid (free_valid),
    .i_free_slot  (free_slot),
    .o_push_valid (push_valid),
    .o_push_id    (push_id),
    .o_push_slot  (push_slot),
    .o_pay_we     (pay_we),
    .o_pay_addr   (pay_addr),
    .o_pay_data   (pay_data),
    .o_credit     (o_credit)
  );

  // Registered payload read drives the egress payload
  simmem_list_store u_list_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_pay_we     (pay_we),
    .i_pay_addr   (pay_addr),
    .i_pay_data   (pay_data),
    .i_pay_re     (pay_re),
    .i_pay_raddr  (pay_raddr),
    .o_pay_rdata  (o_out_payload),
    .i_link_we    (link_we),
    .i_link_addr  (link_addr),
    .i_link_data  (link_data),
    .i_link_raddr (link_raddr),
    .o_link_rdata (link_rdata)
  );

  simmem_release_arb u_release_arb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_push_valid (push_valid),
    .i_push_id    (push_id),
    .i_push_slot  (push_slot),
    .o_link_we    (link_we),
    .o_link_addr  (link_addr),
    .o_link_data  (link_data),
    .o_link_raddr (link_raddr),
    .i_link_rdata (link_rdata),
    .o_pay_re     (pay_re),
    .o_pay_raddr  (pay_raddr),
    .o_free_valid (free_valid),
    .o_free_slot  (free_slot),
    .i_out_ready  (i_out_ready),
    .o_out_valid  (o_out_valid),
    .o_out_id     (o_out_id)
  );

endmodule

// File: dv/simmem_bank_checker.sv
/*
 * Concurrent checks on the message bank top level
 * Egress stability, credit return bound, ingress only with room in the pool
 * Count of failed checks for the testbench
 */

`include "simmem_bank_consts.svh"

module simmem_bank_checker
  import simmem_msg_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input logic         i_in_valid,
  input logic         i_credit,
  input logic         i_free_valid,
  input logic         i_out_valid,
  input msg_id_t      i_out_id,
  input msg_payload_t i_out_payload,
  input logic         i_out_ready
);

  // Running totals since reset
  int free_cnt;
  int credit_cnt;
  int used_cnt;

  // Failed checks since the start of the run
  int fail_cnt = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_cnt   <= 0;
      credit_cnt <= 0;
      used_cnt   <= 0;
    end else begin
      free_cnt   <= free_cnt + (i_free_valid ? 1 : 0);
      credit_cnt <= credit_cnt + (i_credit ? 1 : 0);
      // Slots held by the sender's messages, released by credits
      used_cnt   <= used_cnt + (i_in_valid ? 1 : 0) - (i_credit ? 1 : 0);
    end
  end

  // Egress holds its message under back-pressure
  out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_out_valid && !i_out_ready |=>
      i_out_valid && $stable(i_out_id) && $stable(i_out_payload))
    else begin
      fail_cnt++;
      $error("egress message changed while stalled");
    end

  // No credit without an earlier freed slot
  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_credit |-> credit_cnt < free_cnt)
    else begin
      fail_cnt++;
      $error("credit returned without a freed slot");
    end

  // Ingress only while a slot is left
  pool_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_in_valid |-> used_cnt < `SIMMEM_CAPACITY)
    else begin
      fail_cnt++;
      $error("input accepted with the pool full");
    end

endmodule

bind simmem_bank simmem_bank_checker u_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .i_in_valid    (i_in_valid),
  .i_credit      (o_credit),
  .i_free_valid  (free_valid),
  .i_out_valid   (o_out_valid),
  .i_out_id      (o_out_id),
  .i_out_payload (o_out_payload),
  .i_out_ready   (i_out_ready)
);

// File: dv/simmem_bank_tb.sv
/*
 * Testbench for the linked-list message bank
 * Clock, reset, watchdog, credit-counting driver, per-identifier scoreboard
 * and directed tests
 */

`include "simmem_bank_consts.svh"

module simmem_bank_tb
  import simmem_msg_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_TESTS       = 5;
  localparam int MAX_TEST_CYCLES = 2000;
  localparam int DRAIN_LIMIT     = 100;
  localparam int RAND_MSGS       = 200;

  logic         clk_i;
  logic         rst_ni;
  logic         in_valid;
  msg_id_t      in_id;
  msg_payload_t in_payload;
  logic         credit;
  logic         out_valid;
  msg_id_t      out_id;
  msg_payload_t out_payload;
  logic         out_ready;

  // Credits held by the sender
  int    credits      = `SIMMEM_CAPACITY;
  // All credits seen since reset
  int    credits_back = 0;
  logic  sending;
  string cur_test     = "setup";

  // Expected payloads per identifier, oldest first
  msg_payload_t exp_q [`SIMMEM_NUM_IDS][$];
  // Identifiers in egress order
  msg_id_t      seen_ids [$];

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  simmem_bank u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_in_valid    (in_valid),
    .i_in_id       (in_id),
    .i_in_payload  (in_payload),
    .o_credit      (credit),
    .o_out_valid   (out_valid),
    .o_out_id      (out_id),
    .o_out_payload (out_payload),
    .i_out_ready   (out_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string what, input int exp, input int act);
    $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    stop_run();
  endtask

  task automatic run_error(input string why);
    $display("Error in %s: %s", cur_test, why);
    stop_run();
  endtask

  function automatic bit queues_empty();
    for (int i = 0; i < `SIMMEM_NUM_IDS; i++) begin
      if (exp_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Each transfer must match the oldest message of its identifier
  task automatic check_transfer(input msg_id_t id, input msg_payload_t pay);
    msg_payload_t exp;
    seen_ids.push_back(id);
    assert (exp_q[id].size() != 0)
      else run_error("output on an identifier with no message pending");
    exp = exp_q[id].pop_front();
    assert (pay == exp) else value_error("payload", int'(exp), int'(pay));
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (credit) begin
        credits++;
        credits_back++;
      end
      if (in_valid) begin
        credits--;
      end
      assert (credits <= `SIMMEM_CAPACITY)
        else run_error("more credits returned than slots in the pool");
      if (out_valid && out_ready) begin
        check_transfer(out_id, out_payload);
      end
    end
  end

  always @(negedge clk_i) begin
    if (u_dut.u_checker.fail_cnt != 0) begin
      run_error("a concurrent assertion on the bank failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_msg(input msg_id_t id, input msg_payload_t pay);
    @(posedge clk_i);
    // No credit, no valid
    while (credits == 0) begin
      in_valid <= 1'b0;
      @(posedge clk_i);
    end
    in_valid   <= 1'b1;
    in_id      <= id;
    in_payload <= pay;
    exp_q[id].push_back(pay);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    in_valid <= 1'b0;
  endtask

  // Wait for every message to leave and every credit to come home
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (!queues_empty() || credits != `SIMMEM_CAPACITY) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        run_error("bank did not drain in time");
      end
    end
    // Room for a stray credit to show up
    repeat (4) @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_quiet();
    cur_test = "reset";
    repeat (8) begin
      @(negedge clk_i);
      assert (out_valid == 1'b0) else value_error("o_out_valid", 0, int'(out_valid));
      assert (credit == 1'b0) else value_error("o_credit", 0, int'(credit));
    end
  endtask

  task automatic single_id_order();
    int back0;
    cur_test = "single_id";
    back0 = credits_back;
    for (int k = 1; k <= 5; k++) begin
      send_msg(2'd1, msg_payload_t'(k));
    end
    idle_cycle();
    wait_drain();
    assert (credits_back - back0 == 5)
      else value_error("credits returned", 5, credits_back - back0);
  endtask

  task automatic id_priority();
    msg_id_t order [5];
    msg_id_t exp_ids [$];
    int      start;
    cur_test = "priority";
    order = '{2'd3, 2'd1, 2'd2, 2'd0, 2'd1};
    start = seen_ids.size();
    @(posedge clk_i);
    out_ready <= 1'b0;
    for (int k = 0; k < 5; k++) begin
      send_msg(order[k], msg_payload_t'(32'h3000 + k));
    end
    idle_cycle();
    repeat (4) @(posedge clk_i);
    out_ready <= 1'b1;
    wait_drain();
    // First arrival sits in the output register before the others arrive
    exp_ids.push_back(order[0]);
    // Then ascending identifiers, oldest first
    for (int id = 0; id < `SIMMEM_NUM_IDS; id++) begin
      for (int k = 1; k < 5; k++) begin
        if (order[k] == msg_id_t'(id)) begin
          exp_ids.push_back(order[k]);
        end
      end
    end
    assert (seen_ids.size() - start == exp_ids.size())
      else value_error("transfers", exp_ids.size(), seen_ids.size() - start);
    for (int i = 0; i < exp_ids.size(); i++) begin
      assert (seen_ids[start + i] == exp_ids[i])
        else value_error("identifier", int'(exp_ids[i]), int'(seen_ids[start + i]));
    end
  endtask

  task automatic full_pool();
    int back0;
    cur_test = "full_pool";
    back0 = credits_back;
    @(posedge clk_i);
    out_ready <= 1'b0;
    for (int k = 0; k < `SIMMEM_CAPACITY; k++) begin
      send_msg(msg_id_t'(k % `SIMMEM_NUM_IDS), msg_payload_t'(32'h4000 + k));
    end
    idle_cycle();
    @(posedge clk_i);
    // Every credit spent
    assert (credits == 0) else value_error("credits held", 0, credits);
    out_ready <= 1'b1;
    wait_drain();
    assert (credits_back - back0 == `SIMMEM_CAPACITY)
      else value_error("credits returned", `SIMMEM_CAPACITY, credits_back - back0);
  endtask

  task automatic random_traffic();
    int back0;
    cur_test = "random";
    back0 = credits_back;
    sending = 1'b1;
    fork
      begin
        for (int k = 0; k < RAND_MSGS; k++) begin
          if ($urandom % 4 == 0) begin
            idle_cycle();
          end
          send_msg(msg_id_t'($urandom % `SIMMEM_NUM_IDS), msg_payload_t'($urandom));
        end
        idle_cycle();
        sending = 1'b0;
      end
      // Reader stalls about one cycle in four
      begin
        while (sending) begin
          @(posedge clk_i);
          out_ready <= ($urandom % 4) != 0;
        end
      end
    join
    out_ready <= 1'b1;
    wait_drain();
    assert (credits_back - back0 == RAND_MSGS)
      else value_error("credits returned", RAND_MSGS, credits_back - back0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hbd32));
    rst_ni     <= 1'b0;
    in_valid   <= 1'b0;
    in_id      <= '0;
    in_payload <= '0;
    out_ready  <= 1'b1;
    sending    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_quiet();
    single_id_order();
    id_priority();
    full_pool();
    random_traffic();
    cur_test = "end";
    if (queues_empty() && credits == `SIMMEM_CAPACITY) begin
      $display("all tests passed");
      $finish;
    end else begin
      run_error("messages or credits left over at the end of the run");
    end
  end

  // Budget covers reset plus the longest test for every test
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * MAX_TEST_CYCLES));
    run_error("watchdog expired before the tests finished");
  end

endmodule

// File: simmem_bank.f
+incdir+hw
hw/simmem_msg_pkg.sv
hw/simmem_list_pkg.sv
hw/simmem_slot_alloc.sv
hw/simmem_list_store.sv
hw/simmem_release_arb.sv
hw/simmem_bank.sv
dv/simmem_bank_checker.sv
dv/simmem_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the message bank testbench with Verilator and runs it
# The result is taken from the simulation log

verilator --binary --timing --assert -f simmem_bank.f \
  --top-module simmem_bank_tb -o simmem_bank_sim > build.log 2>&1 &&
  ./obj_dir/simmem_bank_sim > sim.log 2>&1 &&
  grep -q "all tests passed" sim.log &&
  echo "PASS" ||
  { cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
